/* sources.f */
+incdir+include
hdl/fft_num_pkg.sv
hdl/fft_index_pkg.sv
hdl/fft_input_reorder.sv
hdl/fft_stage.sv
hdl/fft_output_drain.sv
hdl/fft_top.sv
tests/fft_top_sva.sv
tests/fft_tb.sv

/* Makefile */
# Verilator build, run, lint and clean for the streaming FFT testbench

VERILATOR ?= verilator
TOP       ?= fft_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* include/fft_model.svh */
// Bit-exact reference FFT with its own twiddle, rounding and clamping helpers
`ifndef FFT_MODEL_SVH
`define FFT_MODEL_SVH

// One part of exp(-j*2*pi*k/n) in Q15, truncated toward zero
function automatic longint twiddle_coef(input int k, input int n, input bit imag);
    real angle;
    real scaled;
    angle = -2.0 * 3.141592653589793 * k / n;
    if (imag) begin
        scaled = $sin(angle) * 32767.0;
    end else begin
        scaled = $cos(angle) * 32767.0;
    end
    return longint'($rtoi(scaled));
endfunction

// Round the product to nearest, then add or subtract and clamp to 16 bits
function automatic longint round_and_clamp(input longint a, input longint prod, input bit sub,
                                           output logic sat);
    longint r;
    longint v;
    r   = (prod + 16384) >>> 15;
    v   = sub ? a - r : a + r;
    sat = 1'b0;
    if (v > 32767) begin
        sat = 1'b1;
        v   = 32767;
    end else if (v < -32768) begin
        sat = 1'b1;
        v   = -32768;
    end
    return v;
endfunction

// Radix-2 DIT over a bit-reversed copy, one stage at a time
function automatic void fft_model(
    input  int                   n,
    input  fft_num_pkg::sample_t in_re  [],
    input  fft_num_pkg::sample_t in_im  [],
    output fft_num_pkg::sample_t res_re [],
    output fft_num_pkg::sample_t res_im [],
    output logic                 res_sat
);
    int     log2n;
    int     h;
    int     rev;
    int     ia;
    int     ib;
    int     tw;
    bit     sub;
    logic   s_re;
    logic   s_im;
    longint w_re;
    longint w_im;
    longint p_re;
    longint p_im;
    longint cur_re [];
    longint cur_im [];
    longint nxt_re [];
    longint nxt_im [];

    log2n   = $clog2(n);
    res_sat = 1'b0;
    cur_re  = new[n];
    cur_im  = new[n];
    nxt_re  = new[n];
    nxt_im  = new[n];

    // Sample i lands at the index with its low log2n bits mirrored
    for (int i = 0; i < n; i++) begin
        rev = 0;
        for (int b = 0; b < log2n; b++) begin
            rev = (rev << 1) | ((i >> b) & 1);
        end
        cur_re[rev] = longint'(in_re[i]);
        cur_im[rev] = longint'(in_im[i]);
    end

    for (int s = 0; s < log2n; s++) begin
        h = 1 << s;
        for (int k = 0; k < n; k++) begin
            ia   = k & ~h;
            ib   = k | h;
            sub  = (k & h) != 0;
            tw   = (k % h) * (n / (2 * h));
            w_re = twiddle_coef(tw, n, 1'b0);
            w_im = twiddle_coef(tw, n, 1'b1);
            // Complex product b*W at full precision
            p_re = cur_re[ib] * w_re - cur_im[ib] * w_im;
            p_im = cur_re[ib] * w_im + cur_im[ib] * w_re;
            nxt_re[k] = round_and_clamp(cur_re[ia], p_re, sub, s_re);
            nxt_im[k] = round_and_clamp(cur_im[ia], p_im, sub, s_im);
            res_sat |= s_re | s_im;
        end
        cur_re = nxt_re;
        cur_im = nxt_im;
    end

    res_re = new[n];
    res_im = new[n];
    for (int k = 0; k < n; k++) begin
        res_re[k] = fft_num_pkg::sample_t'(cur_re[k]);
        res_im[k] = fft_num_pkg::sample_t'(cur_im[k]);
    end
endfunction

`endif

/* tests/fft_tb.sv */
// Testbench for the streaming FFT with random frames, model scoreboard and watchdog
`timescale 1ns/10ps
`default_nettype none

module fft_tb;

    localparam int N             = 16;
    localparam int LOG2          = $clog2(N);
    localparam int RESET_CYCLES  = 5;
    localparam int RANDOM_FRAMES = 8;
    localparam int BURST_FRAMES  = 4;
    localparam int GAP_FRAMES    = 6;
    localparam int SMALL_FRAMES  = 3;
    localparam int SMALL_SPAN    = 1 << 11;
    // Impulse, full scale and the two frames around the mid-run reset
    localparam int NUM_FRAMES =
        1 + RANDOM_FRAMES + BURST_FRAMES + GAP_FRAMES + 1 + SMALL_FRAMES + 2;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * (N + 4 * LOG2 + 10) * 2;

    logic                 clk      = 1'b0;
    logic                 rst_n    = 1'b0;
    logic                 in_valid = 1'b0;
    fft_num_pkg::sample_t in_re    = '0;
    fft_num_pkg::sample_t in_im    = '0;
    logic                 out_valid;
    fft_num_pkg::sample_t out_re;
    fft_num_pkg::sample_t out_im;
    fft_index_pkg::bin_t  out_bin;
    logic                 overflow;

    // Scoreboard, one entry per expected output sample
    string                exp_name_q [$];
    fft_num_pkg::sample_t exp_re_q   [$];
    fft_num_pkg::sample_t exp_im_q   [$];
    fft_index_pkg::bin_t  exp_bin_q  [$];
    logic                 exp_flag_q [$];
    // Flag is only exact mid-frame when the frame itself never saturates
    bit                   flag_known_q [$];
    logic                 model_sticky = 1'b0;
    int                   outputs_seen = 0;
    int                   errors       = 0;

    `include "fft_model.svh"

    fft_top #(
        .FFT_SIZE (N)
    ) i_fft_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_re     (in_re),
        .in_im     (in_im),
        .out_valid (out_valid),
        .out_re    (out_re),
        .out_im    (out_im),
        .out_bin   (out_bin),
        .overflow  (overflow)
    );

    always #4 clk = ~clk;

    // ========================================
    // Checks
    // ========================================
    task automatic report_failure(input string why);
        errors++;
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_sample(input string name, input fft_num_pkg::sample_t exp,
                                input fft_num_pkg::sample_t act);
        if (act !== exp) begin
            report_failure($sformatf("MISMATCH %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_bin(input string name, input fft_index_pkg::bin_t exp,
                             input fft_index_pkg::bin_t act);
        if (act !== exp) begin
            report_failure($sformatf("MISMATCH %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // Pop the oldest expected sample and compare it with the DUT outputs
    task automatic check_output();
        string name;
        logic  flag;
        bit    known;
        if (exp_re_q.size() == 0) begin
            report_failure("DUT produced an output sample while no frame was outstanding");
        end else begin
            name  = exp_name_q.pop_front();
            flag  = exp_flag_q.pop_front();
            known = flag_known_q.pop_front();
            check_bin({name, " bin"}, exp_bin_q.pop_front(), out_bin);
            check_sample({name, " re"}, exp_re_q.pop_front(), out_re);
            check_sample({name, " im"}, exp_im_q.pop_front(), out_im);
            if (known) begin
                check_flag({name, " overflow"}, flag, overflow);
            end
            outputs_seen++;
        end
    endtask

    // Outputs are registered on the rising edge, so sample them on the falling one
    always @(negedge clk) begin
        if (!rst_n) begin
            check_flag("reset out_valid", 1'b0, out_valid);
            check_flag("reset overflow", 1'b0, overflow);
        end else if (out_valid) begin
            check_output();
        end
    end

    // Bounded run time
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure($sformatf("Timeout: run did not finish within %0d clock cycles",
                                 WATCHDOG_CYCLES));
    end

    // ========================================
    // Stimulus helpers
    // ========================================
    function automatic fft_num_pkg::sample_t rand_part(input int span);
        int v;
        v = int'($urandom_range(2 * span - 1, 0)) - span;
        return fft_num_pkg::sample_t'(v);
    endfunction

    task automatic random_frame(input int span, output fft_num_pkg::sample_t f_re [],
                                output fft_num_pkg::sample_t f_im []);
        f_re = new[N];
        f_im = new[N];
        for (int i = 0; i < N; i++) begin
            f_re[i] = rand_part(span);
            f_im[i] = rand_part(span);
        end
    endtask

    // One sample per strobe, optional random idle cycles before each one
    task automatic drive_frame(input fft_num_pkg::sample_t f_re [],
                               input fft_num_pkg::sample_t f_im [], input int max_gap);
        int gap;
        for (int i = 0; i < N; i++) begin
            gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
            repeat (gap) begin
                @(posedge clk);
                #1;
                in_valid = 1'b0;
            end
            @(posedge clk);
            #1;
            in_valid = 1'b1;
            in_re    = f_re[i];
            in_im    = f_im[i];
        end
    endtask

    task automatic push_frame(input string name, input fft_num_pkg::sample_t e_re [],
                              input fft_num_pkg::sample_t e_im [], input logic sat);
        logic after;
        after = model_sticky | sat;
        for (int k = 0; k < N; k++) begin
            exp_name_q.push_back(name);
            exp_re_q.push_back(e_re[k]);
            exp_im_q.push_back(e_im[k]);
            exp_bin_q.push_back(fft_index_pkg::bin_t'(k));
            exp_flag_q.push_back(after);
            flag_known_q.push_back(!sat || k == N - 1);
        end
        model_sticky = after;
    endtask

    task automatic send_frame(input string name, input fft_num_pkg::sample_t f_re [],
                              input fft_num_pkg::sample_t f_im [], input int max_gap);
        fft_num_pkg::sample_t m_re [];
        fft_num_pkg::sample_t m_im [];
        logic                 m_sat;
        fft_model(N, f_re, f_im, m_re, m_im, m_sat);
        drive_frame(f_re, f_im, max_gap);
        push_frame(name, m_re, m_im, m_sat);
    endtask

    // Stop driving and let every outstanding frame come out
    task automatic wait_drained();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        while (exp_re_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    // In-flight frames are lost, so the scoreboard starts over
    task automatic do_reset();
        @(posedge clk);
        #1;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        exp_name_q.delete();
        exp_re_q.delete();
        exp_im_q.delete();
        exp_bin_q.delete();
        exp_flag_q.delete();
        flag_known_q.delete();
        model_sticky = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        fft_num_pkg::sample_t f_re [];
        fft_num_pkg::sample_t f_im [];
        fft_num_pkg::sample_t e_re [];
        fft_num_pkg::sample_t e_im [];
        int                   start_count;

        void'($urandom(42));
        do_reset();

        // Impulse spreads flat over all bins
        f_re = new[N];
        f_im = new[N];
        e_re = new[N];
        e_im = new[N];
        for (int i = 0; i < N; i++) begin
            f_re[i] = (i == 0) ? fft_num_pkg::sample_t'(1000) : '0;
            f_im[i] = '0;
            e_re[i] = fft_num_pkg::sample_t'(1000);
            e_im[i] = '0;
        end
        drive_frame(f_re, f_im, 0);
        push_frame("impulse", e_re, e_im, 1'b0);
        wait_drained();

        for (int f = 0; f < RANDOM_FRAMES; f++) begin
            random_frame(SMALL_SPAN, f_re, f_im);
            send_frame("random", f_re, f_im, 0);
        end
        wait_drained();

        // Back-to-back frames, then strobes with idle gaps
        for (int f = 0; f < BURST_FRAMES; f++) begin
            random_frame(SMALL_SPAN, f_re, f_im);
            send_frame("burst", f_re, f_im, 0);
        end
        for (int f = 0; f < GAP_FRAMES; f++) begin
            random_frame(SMALL_SPAN, f_re, f_im);
            send_frame("gaps", f_re, f_im, 2);
        end
        wait_drained();

        // Full scale overflows in stage 0
        for (int i = 0; i < N; i++) begin
            f_re[i] = fft_num_pkg::sample_t'(32767);
            f_im[i] = fft_num_pkg::sample_t'(-32768);
        end
        send_frame("full_scale", f_re, f_im, 0);
        for (int f = 0; f < SMALL_FRAMES; f++) begin
            random_frame(SMALL_SPAN, f_re, f_im);
            send_frame("after_saturation", f_re, f_im, 0);
        end
        wait_drained();
        check_flag("overflow sticky", 1'b1, overflow);

        // Reset halfway through an output frame
        start_count = outputs_seen;
        random_frame(SMALL_SPAN, f_re, f_im);
        send_frame("before_reset", f_re, f_im, 0);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        while (outputs_seen < start_count + N / 2) begin
            @(posedge clk);
        end
        do_reset();
        random_frame(SMALL_SPAN, f_re, f_im);
        send_frame("after_reset", f_re, f_im, 0);
        wait_drained();

        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/fft_top_sva.sv */
// Bound assertions on the FFT top-level output strobe, bin number and overflow flag
`timescale 1ns/10ps
`default_nettype none

module fft_top_sva #(
    parameter int FFT_SIZE = 16
) (
    input logic                clk,
    input logic                rst_n,
    input logic                out_valid,
    input fft_index_pkg::bin_t out_bin,
    input logic                overflow
);

    localparam fft_index_pkg::bin_t LAST = fft_index_pkg::bin_t'(FFT_SIZE - 1);

    // Bin of the previous strobe since reset
    fft_index_pkg::bin_t prev_bin;
    fft_index_pkg::bin_t next_bin;
    logic                seen;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_bin <= '0;
            seen     <= 1'b0;
        end else if (out_valid) begin
            prev_bin <= out_bin;
            seen     <= 1'b1;
        end
    end

    assign next_bin = (prev_bin == LAST) ? '0 : prev_bin + 1'b1;

    // Held reset keeps the strobe quiet
    a_valid_in_reset: assert property (@(posedge clk) (!rst_n && $past(!rst_n)) |-> !out_valid)
        else $error("out_valid high while reset is held");

    a_first_bin: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !seen) |-> out_bin == '0)
        else $error("first bin after reset is not zero");

    // Wraps at the frame length
    a_bin_step: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && seen) |-> out_bin == next_bin)
        else $error("out_bin did not step by one between strobes");

    a_overflow_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        $past(overflow) |-> overflow)
        else $error("overflow fell while out of reset");

endmodule

bind fft_top fft_top_sva #(
    .FFT_SIZE (FFT_SIZE)
) i_fft_top_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .out_bin   (out_bin),
    .overflow  (overflow)
);

`default_nettype wire

/* hdl/fft_top.sv */
// Streaming FFT top with reorder, generated butterfly stages and output drain
`timescale 1ns/10ps
`default_nettype none

module fft_top #(
    parameter int FFT_SIZE = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  fft_num_pkg::sample_t in_re,
    input  fft_num_pkg::sample_t in_im,
    output logic                 out_valid,
    output fft_num_pkg::sample_t out_re,
    output fft_num_pkg::sample_t out_im,
    output fft_index_pkg::bin_t  out_bin,
    output logic                 overflow
);

    localparam int STAGES = $clog2(FFT_SIZE);

    // Size must be a power of two within the supported range
    if (FFT_SIZE < fft_index_pkg::MIN_SIZE || FFT_SIZE > fft_index_pkg::MAX_SIZE ||
        (FFT_SIZE & (FFT_SIZE - 1)) != 0) begin : g_size_check
        $error("FFT_SIZE must be a power of two from 4 to 1024");
    end

    // Link s feeds stage s, link STAGES feeds the drain
    logic                 link_valid [STAGES+1];
    logic                 link_sat   [STAGES+1];
    fft_num_pkg::sample_t link_re    [STAGES+1];
    fft_num_pkg::sample_t link_im    [STAGES+1];

    // No saturation can exist before the first stage
    assign link_sat[0] = 1'b0;

    // ========================================
    // Datapath chain
    // ========================================
    fft_input_reorder #(
        .FFT_SIZE (FFT_SIZE)
    ) i_reorder (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_re     (in_re),
        .in_im     (in_im),
        .out_valid (link_valid[0]),
        .out_re    (link_re[0]),
        .out_im    (link_im[0])
    );

    for (genvar s = 0; s < STAGES; s++) begin : g_stage
        fft_stage #(
            .FFT_SIZE (FFT_SIZE),
            .STAGE    (s)
        ) i_stage (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (link_valid[s]),
            .in_sat    (link_sat[s]),
            .in_re     (link_re[s]),
            .in_im     (link_im[s]),
            .out_valid (link_valid[s+1]),
            .out_sat   (link_sat[s+1]),
            .out_re    (link_re[s+1]),
            .out_im    (link_im[s+1])
        );
    end

    fft_output_drain #(
        .FFT_SIZE (FFT_SIZE)
    ) i_drain (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (link_valid[STAGES]),
        .in_sat    (link_sat[STAGES]),
        .in_re     (link_re[STAGES]),
        .in_im     (link_im[STAGES]),
        .out_valid (out_valid),
        .out_re    (out_re),
        .out_im    (out_im),
        .out_bin   (out_bin),
        .overflow  (overflow)
    );

endmodule

`default_nettype wire

/* hdl/fft_output_drain.sv */
// Output register, bin counter and sticky overflow flag
`timescale 1ns/10ps
`default_nettype none

module fft_output_drain #(
    parameter int FFT_SIZE = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  logic                 in_sat,
    input  fft_num_pkg::sample_t in_re,
    input  fft_num_pkg::sample_t in_im,
    output logic                 out_valid,
    output fft_num_pkg::sample_t out_re,
    output fft_num_pkg::sample_t out_im,
    output fft_index_pkg::bin_t  out_bin,
    output logic                 overflow
);

    localparam fft_index_pkg::bin_t LAST = fft_index_pkg::bin_t'(FFT_SIZE - 1);

    // Bin number of the next sample
    fft_index_pkg::bin_t bin_cnt;

    // ========================================
    // Control and flag
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_bin   <= '0;
            bin_cnt   <= '0;
            overflow  <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                out_bin <= bin_cnt;
                bin_cnt <= (bin_cnt == LAST) ? '0 : bin_cnt + 1'b1;
            end
            // Sticky until reset
            if (in_valid && in_sat) begin
                overflow <= 1'b1;
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_re <= in_re;
            out_im <= in_im;
        end
    end

endmodule

`default_nettype wire

/* hdl/fft_stage.sv */
// One radix-2 butterfly stage with frame banks, twiddle table and read/multiply/add pipeline
`timescale 1ns/10ps
`default_nettype none

module fft_stage #(
    parameter int FFT_SIZE = 16,
    parameter int STAGE    = 0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  logic                 in_sat,
    input  fft_num_pkg::sample_t in_re,
    input  fft_num_pkg::sample_t in_im,
    output logic                 out_valid,
    output logic                 out_sat,
    output fft_num_pkg::sample_t out_re,
    output fft_num_pkg::sample_t out_im
);

    localparam int                  LOG2      = $clog2(FFT_SIZE);
    localparam int                  HALF_SPAN = 1 << STAGE;
    // Twiddle step N/(2h) as a shift
    localparam int                  TW_SHIFT  = LOG2 - 1 - STAGE;
    localparam fft_index_pkg::bin_t LAST      = fft_index_pkg::bin_t'(FFT_SIZE - 1);
    localparam fft_index_pkg::bin_t SPAN_BIT  = fft_index_pkg::bin_t'(HALF_SPAN);

    // Frame banks with per-sample saturation marks
    fft_num_pkg::sample_t bank_re  [2][FFT_SIZE];
    fft_num_pkg::sample_t bank_im  [2][FFT_SIZE];
    logic                 bank_sat [2][FFT_SIZE];

    fft_num_pkg::twiddle_t tw_re [FFT_SIZE/2];
    fft_num_pkg::twiddle_t tw_im [FFT_SIZE/2];

    logic                fill_bank;
    fft_index_pkg::bin_t fill_cnt;
    logic                run_active;
    fft_index_pkg::bin_t run_cnt;
    fft_index_pkg::bin_t idx_a;
    fft_index_pkg::bin_t idx_b;
    fft_index_pkg::bin_t tw_idx;

    // Read step
    logic                  rd_valid;
    logic                  rd_sub;
    logic                  rd_sat;
    fft_num_pkg::sample_t  rd_a_re, rd_a_im, rd_b_re, rd_b_im;
    fft_num_pkg::twiddle_t rd_w_re, rd_w_im;

    // Multiply step
    logic                  mul_valid;
    logic                  mul_sub;
    logic                  mul_sat;
    fft_num_pkg::sample_t  mul_a_re, mul_a_im;
    fft_num_pkg::product_t mul_p_re, mul_p_im;

    // Add and saturate
    fft_num_pkg::product_t rnd_re, rnd_im;
    fft_num_pkg::sample_t  sum_re, sum_im;
    logic                  sat_re, sat_im;

    // Twiddle ROM, constant per frame size
    for (genvar t = 0; t < FFT_SIZE / 2; t++) begin : g_twiddle
        assign tw_re[t] = fft_num_pkg::twiddle_re(t, FFT_SIZE);
        assign tw_im[t] = fft_num_pkg::twiddle_im(t, FFT_SIZE);
    end

    // ========================================
    // Frame capture
    // ========================================
    always_ff @(posedge clk) begin
        if (in_valid) begin
            bank_re[fill_bank][fill_cnt[LOG2-1:0]]  <= in_re;
            bank_im[fill_bank][fill_cnt[LOG2-1:0]]  <= in_im;
            bank_sat[fill_bank][fill_cnt[LOG2-1:0]] <= in_sat;
        end
    end

    // Fill counter, bank swap and run start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt   <= '0;
            fill_bank  <= 1'b0;
            run_active <= 1'b0;
            run_cnt    <= '0;
        end else begin
            if (in_valid) begin
                fill_cnt <= (fill_cnt == LAST) ? '0 : fill_cnt + 1'b1;
            end
            if (in_valid && fill_cnt == LAST) begin
                fill_bank  <= ~fill_bank;
                run_active <= 1'b1;
                run_cnt    <= '0;
            end else if (run_active) begin
                run_cnt <= run_cnt + 1'b1;
                if (run_cnt == LAST) begin
                    run_active <= 1'b0;
                end
            end
        end
    end

    // ========================================
    // Butterfly pipeline
    // ========================================
    // Upper partner has bit STAGE clear, lower has it set
    assign idx_a  = run_cnt & ~SPAN_BIT;
    assign idx_b  = run_cnt | SPAN_BIT;
    assign tw_idx = (run_cnt & (SPAN_BIT - 1'b1)) << TW_SHIFT;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid  <= 1'b0;
            mul_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            rd_valid  <= run_active;
            mul_valid <= rd_valid;
            out_valid <= mul_valid;
        end
    end

    // Step 1, read pair and twiddle from the finished bank
    always_ff @(posedge clk) begin
        rd_a_re <= bank_re[~fill_bank][idx_a[LOG2-1:0]];
        rd_a_im <= bank_im[~fill_bank][idx_a[LOG2-1:0]];
        rd_b_re <= bank_re[~fill_bank][idx_b[LOG2-1:0]];
        rd_b_im <= bank_im[~fill_bank][idx_b[LOG2-1:0]];
        rd_sat  <= bank_sat[~fill_bank][idx_a[LOG2-1:0]] | bank_sat[~fill_bank][idx_b[LOG2-1:0]];
        rd_w_re <= tw_re[tw_idx[LOG2-2:0]];
        rd_w_im <= tw_im[tw_idx[LOG2-2:0]];
        rd_sub  <= run_cnt[STAGE];
    end

    // Step 2, complex product b*W at full width
    always_ff @(posedge clk) begin
        mul_p_re <= rd_b_re * rd_w_re - rd_b_im * rd_w_im;
        mul_p_im <= rd_b_re * rd_w_im + rd_b_im * rd_w_re;
        mul_a_re <= rd_a_re;
        mul_a_im <= rd_a_im;
        mul_sub  <= rd_sub;
        mul_sat  <= rd_sat;
    end

    // Step 3, round then a + Wb or a - Wb with clamping
    always_comb begin
        rnd_re = fft_num_pkg::round_product(mul_p_re);
        rnd_im = fft_num_pkg::round_product(mul_p_im);
        if (mul_sub) begin
            sum_re = fft_num_pkg::sat_sub(mul_a_re, rnd_re, sat_re);
            sum_im = fft_num_pkg::sat_sub(mul_a_im, rnd_im, sat_im);
        end else begin
            sum_re = fft_num_pkg::sat_add(mul_a_re, rnd_re, sat_re);
            sum_im = fft_num_pkg::sat_add(mul_a_im, rnd_im, sat_im);
        end
    end

    always_ff @(posedge clk) begin
        out_re  <= sum_re;
        out_im  <= sum_im;
        // Mark carries any earlier saturation forward
        out_sat <= mul_sat | sat_re | sat_im;
    end

endmodule

`default_nettype wire

/* hdl/fft_input_reorder.sv */
// Input reorder with bit-reversed capture into ping-pong banks and in-order drain
`timescale 1ns/10ps
`default_nettype none

module fft_input_reorder #(
    parameter int FFT_SIZE = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  fft_num_pkg::sample_t in_re,
    input  fft_num_pkg::sample_t in_im,
    output logic                 out_valid,
    output fft_num_pkg::sample_t out_re,
    output fft_num_pkg::sample_t out_im
);

    localparam int                  LOG2 = $clog2(FFT_SIZE);
    localparam fft_index_pkg::bin_t LAST = fft_index_pkg::bin_t'(FFT_SIZE - 1);

    // Two frame banks, one filling while the other drains
    fft_num_pkg::sample_t bank_re [2][FFT_SIZE];
    fft_num_pkg::sample_t bank_im [2][FFT_SIZE];

    logic                fill_bank;
    fft_index_pkg::bin_t fill_cnt;
    fft_index_pkg::bin_t wr_addr;
    logic                drain_active;
    fft_index_pkg::bin_t drain_cnt;

    // ========================================
    // Fill side
    // ========================================
    assign wr_addr = fft_index_pkg::bit_reverse(fill_cnt, LOG2);

    always_ff @(posedge clk) begin
        if (in_valid) begin
            bank_re[fill_bank][wr_addr[LOG2-1:0]] <= in_re;
            bank_im[fill_bank][wr_addr[LOG2-1:0]] <= in_im;
        end
    end

    // Frame counter and bank swap on the last sample
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt  <= '0;
            fill_bank <= 1'b0;
        end else if (in_valid) begin
            if (fill_cnt == LAST) begin
                fill_cnt  <= '0;
                fill_bank <= ~fill_bank;
            end else begin
                fill_cnt <= fill_cnt + 1'b1;
            end
        end
    end

    // ========================================
    // Drain side
    // ========================================
    // Starts the cycle after the frame completes, N cycles long
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drain_active <= 1'b0;
            drain_cnt    <= '0;
        end else if (in_valid && fill_cnt == LAST) begin
            drain_active <= 1'b1;
            drain_cnt    <= '0;
        end else if (drain_active) begin
            drain_cnt <= drain_cnt + 1'b1;
            if (drain_cnt == LAST) begin
                drain_active <= 1'b0;
            end
        end
    end

    // Finished bank is always the one not filling
    assign out_valid = drain_active;
    assign out_re    = bank_re[~fill_bank][drain_cnt[LOG2-1:0]];
    assign out_im    = bank_im[~fill_bank][drain_cnt[LOG2-1:0]];

endmodule

`default_nettype wire

/* hdl/fft_index_pkg.sv */
// Index and bin widths, frame size limits and bit reversal
`default_nettype none

package fft_index_pkg;

    // Largest supported frame is 2^MAX_LOG2
    localparam int MAX_LOG2 = 10;
    localparam int MIN_SIZE = 4;
    localparam int MAX_SIZE = 1 << MAX_LOG2;

    // Sample or bin number, bits above log2 of the size stay zero
    typedef logic [MAX_LOG2-1:0] bin_t;

    // Mirror the low log2n bits, upper bits cleared
    function automatic bin_t bit_reverse(input bin_t idx, input int log2n);
        bin_t rev;
        rev = '0;
        for (int i = 0; i < MAX_LOG2; i++) begin
            if (i < log2n) begin
                rev[i] = idx[log2n-1-i];
            end
        end
        return rev;
    endfunction

endpackage

`default_nettype wire

/* hdl/fft_num_pkg.sv */
// Sample and twiddle formats, twiddle generation, rounding and saturating arithmetic
`default_nettype none

package fft_num_pkg;

    // ========================================
    // Number formats
    // ========================================
    localparam int SAMPLE_WIDTH  = 16;
    localparam int TWIDDLE_WIDTH = 16;
    localparam int PRODUCT_WIDTH = SAMPLE_WIDTH + TWIDDLE_WIDTH + 1;

    typedef logic signed [SAMPLE_WIDTH-1:0]  sample_t;
    typedef logic signed [TWIDDLE_WIDTH-1:0] twiddle_t;
    // One part of b*W, with headroom for the sum of two products
    typedef logic signed [PRODUCT_WIDTH-1:0] product_t;

    localparam real      PI          = 3.141592653589793;
    localparam int       TWIDDLE_MAX = (1 << (TWIDDLE_WIDTH - 1)) - 1;
    localparam product_t ROUND_BIAS  = product_t'(1) <<< (TWIDDLE_WIDTH - 2);
    localparam product_t SAT_HI      = (product_t'(1) <<< (SAMPLE_WIDTH - 1)) - 1;
    localparam product_t SAT_LO      = -(product_t'(1) <<< (SAMPLE_WIDTH - 1));

    // ========================================
    // Twiddle factors W = exp(-j*2*pi*k/size)
    // ========================================
    function automatic twiddle_t twiddle_re(input int k, input int size);
        real angle;
        angle = -2.0 * PI * k / size;
        // $rtoi truncates toward zero
        return twiddle_t'($rtoi($cos(angle) * TWIDDLE_MAX));
    endfunction

    function automatic twiddle_t twiddle_im(input int k, input int size);
        real angle;
        angle = -2.0 * PI * k / size;
        return twiddle_t'($rtoi($sin(angle) * TWIDDLE_MAX));
    endfunction

    // Round to nearest, back to sample scale but still wide
    function automatic product_t round_product(input product_t p);
        return (p + ROUND_BIAS) >>> (TWIDDLE_WIDTH - 1);
    endfunction

    // Clamp a wide value into sample range
    function automatic sample_t clamp(input product_t v, output logic sat);
        sat = (v > SAT_HI) || (v < SAT_LO);
        if (v > SAT_HI) begin
            return sample_t'(SAT_HI);
        end
        if (v < SAT_LO) begin
            return sample_t'(SAT_LO);
        end
        return sample_t'(v);
    endfunction

    function automatic sample_t sat_add(input sample_t a, input product_t b, output logic sat);
        return clamp(product_t'(a) + b, sat);
    endfunction

    function automatic sample_t sat_sub(input sample_t a, input product_t b, output logic sat);
        return clamp(product_t'(a) - b, sat);
    endfunction

endpackage

`default_nettype wire
